/* source/flow_pkg.sv */
/*
 * Shared package for the flow merger: default sizes, the skid buffer
 * occupancy enum and the round-robin index wrap helper
 */

`default_nettype none

package flow_pkg;

  // Default number of merged input flows
  localparam int NUM_FLOWS_DEFAULT = 4;

  // Default payload width in bits
  localparam int DATA_WIDTH_DEFAULT = 16;

  // Skid buffer occupancy
  typedef enum logic [1:0] {
    skid_empty = 2'd0,
    skid_one   = 2'd1,
    skid_two   = 2'd2
  } skid_state_e;

  // Folds an index in the range [0, 2*n) back into [0, n)
  // Callers only ever add less than n to a valid index
  function automatic int unsigned rr_wrap(input int unsigned idx, input int unsigned n);
    int unsigned result;
    result = idx;
    if (idx >= n) begin
      result = idx - n;
    end
    return result;
  endfunction

endpackage : flow_pkg

`default_nettype wire

/* source/flow_skid.sv */
/*
 * Two-entry skid buffer with a registered push_ready and registered
 * pop_data, used once per input flow
 */

`timescale 1ns/100ps
`default_nettype none

module flow_skid import flow_pkg::*; #(
  parameter int DataWidth = 1  // Must be at least 1
) (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 push_valid,
  output logic                 push_ready,
  input  logic [DataWidth-1:0] push_data,
  output logic                 pop_valid,
  input  logic                 pop_ready,
  output logic [DataWidth-1:0] pop_data
);

  // ----------------------------------------------------------
  // Storage and control
  // ----------------------------------------------------------

  skid_state_e          state_q;
  skid_state_e          state_d;

  // Main register always holds the oldest beat
  logic [DataWidth-1:0] main_q;
  // Skid register catches the beat that arrives during a stall
  logic [DataWidth-1:0] skid_q;

  logic                 push_xfer;
  logic                 pop_xfer;
  logic                 load_main;
  logic                 load_from_skid;
  logic                 load_skid;

  assign push_xfer = push_valid && push_ready;
  assign pop_xfer  = pop_valid && pop_ready;

  // Output side comes straight from registers
  assign pop_valid = (state_q != skid_empty);
  assign pop_data  = main_q;

  // ----------------------------------------------------------
  // Next state and register load enables
  // ----------------------------------------------------------

  always_comb begin
    state_d        = state_q;
    load_main      = 1'b0;
    load_from_skid = 1'b0;
    load_skid      = 1'b0;
    unique case (state_q)
      skid_empty: begin
        // First beat goes directly to the output register
        if (push_xfer) begin
          state_d   = skid_one;
          load_main = 1'b1;
        end
      end
      skid_one: begin
        if (push_xfer && pop_xfer) begin
          // Streaming, so the new beat replaces the departing one
          load_main = 1'b1;
        end else if (push_xfer) begin
          // Output stalled, park the new beat behind the main one
          state_d   = skid_two;
          load_skid = 1'b1;
        end else if (pop_xfer) begin
          state_d = skid_empty;
        end
      end
      skid_two: begin
        // push_ready is low here, only the output side can move
        if (pop_xfer) begin
          state_d        = skid_one;
          load_main      = 1'b1;
          load_from_skid = 1'b1;
        end
      end
      default: begin
        state_d = skid_empty;
      end
    endcase
  end

  // ----------------------------------------------------------
  // Registers
  // ----------------------------------------------------------

  // push_ready is registered from the next state
  // Keeps the downstream ready off the upstream timing path
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q    <= skid_empty;
      push_ready <= 1'b1;
    end else begin
      state_q    <= state_d;
      push_ready <= (state_d != skid_two);
    end
  end

  // Payload registers
  always_ff @(posedge clk) begin
    if (load_main) begin
      main_q <= load_from_skid ? skid_q : push_data;
    end
    if (load_skid) begin
      skid_q <= push_data;
    end
  end

endmodule : flow_skid

`default_nettype wire

/* source/flow_arb_rr.sv */
/*
 * Round-robin arbiter with ready/valid flows on the push side and a
 * single grant handshake on the pop side
 */

`timescale 1ns/100ps
`default_nettype none

module flow_arb_rr import flow_pkg::*; #(
  parameter int NumFlows = 2  // Must be at least 2
) (
  input  logic                clk,
  input  logic                rst,
  input  logic [NumFlows-1:0] push_valid,
  output logic [NumFlows-1:0] push_ready,
  input  logic                pop_ready,
  output logic                pop_valid
);

  localparam int IdxWidth = $clog2(NumFlows);

  // ----------------------------------------------------------
  // Priority pointer and winner search
  // ----------------------------------------------------------

  // Flow with the highest priority in the current cycle
  logic [IdxWidth-1:0] ptr_q;
  // First valid flow at or after the pointer
  logic [IdxWidth-1:0] win_idx;

  // Any request is enough to present a valid grant
  assign pop_valid = |push_valid;

  // Scan from the pointer upward and wrap at NumFlows
  always_comb begin
    int unsigned cand;
    logic        found;
    cand    = 0;
    found   = 1'b0;
    win_idx = ptr_q;
    for (int off = 0; off < NumFlows; off++) begin
      cand = rr_wrap(int'(ptr_q) + off, NumFlows);
      if (!found && push_valid[cand]) begin
        found   = 1'b1;
        win_idx = IdxWidth'(cand);
      end
    end
  end

  // ----------------------------------------------------------
  // Grant
  // ----------------------------------------------------------

  // Onehot0 ready back to the flows
  // No grant at all while the consumer stalls
  always_comb begin
    push_ready = '0;
    if (pop_valid && pop_ready) begin
      push_ready[win_idx] = 1'b1;
    end
  end

  // ----------------------------------------------------------
  // Pointer update
  // ----------------------------------------------------------

  // After a transfer the winner drops to lowest priority
  // Pointer holds while nothing moves, so the winner stays put
  always_ff @(posedge clk) begin
    if (rst) begin
      ptr_q <= '0;
    end else if (pop_valid && pop_ready) begin
      ptr_q <= IdxWidth'(rr_wrap(int'(win_idx) + 1, NumFlows));
    end
  end

endmodule : flow_arb_rr

`default_nettype wire

/* source/flow_mux_rr.sv */
/*
 * Round-robin flow multiplexer: arbiter plus grant index encoding and
 * data selection, zero latency from push to pop
 */

`timescale 1ns/100ps
`default_nettype none

module flow_mux_rr #(
  parameter int NumFlows  = 2,  // Must be at least 2
  parameter int DataWidth = 1   // Must be at least 1
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [NumFlows-1:0]                push_valid,
  output logic [NumFlows-1:0]                push_ready,
  input  logic [NumFlows-1:0][DataWidth-1:0] push_data,
  input  logic                               pop_ready,
  output logic                               pop_valid,
  output logic [DataWidth-1:0]               pop_data,
  output logic [$clog2(NumFlows)-1:0]        pop_flow
);

  localparam int IdxWidth = $clog2(NumFlows);

  // ----------------------------------------------------------
  // Arbitration
  // ----------------------------------------------------------

  flow_arb_rr #(
    .NumFlows(NumFlows)
  ) i_arb (
    .clk       (clk),
    .rst       (rst),
    .push_valid(push_valid),
    .push_ready(push_ready),
    .pop_ready (pop_ready),
    .pop_valid (pop_valid)
  );

  // ----------------------------------------------------------
  // Grant index and data select
  // ----------------------------------------------------------

  logic [IdxWidth-1:0] grant_idx;

  // Granted and valid is onehot0
  // OR of the matching indices is therefore the index itself
  always_comb begin
    grant_idx = '0;
    for (int i = 0; i < NumFlows; i++) begin
      if (push_ready[i] && push_valid[i]) begin
        grant_idx = grant_idx | IdxWidth'(i);
      end
    end
  end

  // Source flow travels with the beat
  assign pop_flow = grant_idx;
  assign pop_data = push_data[grant_idx];

endmodule : flow_mux_rr

`default_nettype wire

/* source/flow_merge_top.sv */
/*
 * Flow merger top level: one skid buffer per input flow feeding the
 * round-robin flow multiplexer
 */

`timescale 1ns/100ps
`default_nettype none

module flow_merge_top import flow_pkg::*; #(
  parameter int NumFlows  = NUM_FLOWS_DEFAULT,   // Must be at least 2
  parameter int DataWidth = DATA_WIDTH_DEFAULT   // Must be at least 1
) (
  input  logic                               clk,
  input  logic                               rst,

  // Producer side, one ready/valid stream per flow
  input  logic [NumFlows-1:0]                push_valid,
  output logic [NumFlows-1:0]                push_ready,
  input  logic [NumFlows-1:0][DataWidth-1:0] push_data,

  // Consumer side, merged stream tagged with its source flow
  output logic                               pop_valid,
  input  logic                               pop_ready,
  output logic [DataWidth-1:0]               pop_data,
  output logic [$clog2(NumFlows)-1:0]        pop_flow
);

  // ----------------------------------------------------------
  // Skid buffer outputs into the multiplexer
  // ----------------------------------------------------------

  logic [NumFlows-1:0]                mux_valid;
  logic [NumFlows-1:0]                mux_ready;
  logic [NumFlows-1:0][DataWidth-1:0] mux_data;

  // Per-flow buffering
  // Registered push_ready isolates each producer from the arbiter
  for (genvar i = 0; i < NumFlows; i++) begin : g_flow
    flow_skid #(
      .DataWidth(DataWidth)
    ) i_skid (
      .clk       (clk),
      .rst       (rst),
      .push_valid(push_valid[i]),
      .push_ready(push_ready[i]),
      .push_data (push_data[i]),
      .pop_valid (mux_valid[i]),
      .pop_ready (mux_ready[i]),
      .pop_data  (mux_data[i])
    );
  end

  // ----------------------------------------------------------
  // Merge
  // ----------------------------------------------------------

  // Fair arbitration, one beat per transfer, zero latency
  flow_mux_rr #(
    .NumFlows (NumFlows),
    .DataWidth(DataWidth)
  ) i_mux (
    .clk       (clk),
    .rst       (rst),
    .push_valid(mux_valid),
    .push_ready(mux_ready),
    .push_data (mux_data),
    .pop_ready (pop_ready),
    .pop_valid (pop_valid),
    .pop_data  (pop_data),
    .pop_flow  (pop_flow)
  );

endmodule : flow_merge_top

`default_nettype wire

/* tb/tb_flow_merge_tests.svh */
/*
 * Directed tests of the flow merger and the cycle driver, reset and
 * scoreboard helpers they share
 */

`ifndef TB_FLOW_MERGE_TESTS_SVH
`define TB_FLOW_MERGE_TESTS_SVH

// ------------------------------------------------------------
// Helpers
// ------------------------------------------------------------

// Synchronous reset with idle producers, stale beats dropped
task automatic reset_dut();
  rst        <= 1'b1;
  push_valid <= '0;
  pop_ready  <= 1'b0;
  for (int f = 0; f < num_flows; f++) begin
    src_q[f].delete();
    exp_q[f].delete();
  end
  repeat (reset_cycles) @(posedge clk);
  rst <= 1'b0;
endtask

// One rising edge: free producers offer their next beat with push_pct percent chance
task automatic drive_cycle(input int unsigned push_pct, input logic pop_rdy);
  @(posedge clk);
  for (int f = 0; f < num_flows; f++) begin
    // Free when idle or when the held beat moves on this edge
    if (!push_valid[f] || push_taken[f]) begin
      if (src_q[f].size() > 0 && $urandom_range(99) < push_pct) begin
        push_valid[f] <= 1'b1;
        push_data[f]  <= src_q[f].pop_front();
      end else begin
        push_valid[f] <= 1'b0;
      end
    end
  end
  pop_ready <= pop_rdy;
endtask

// Consumer ready until the pop count reaches target
task automatic run_until_popped(input int target, input int unsigned push_pct,
                                input int limit, input string name);
  int cycles;
  cycles = 0;
  while (pop_cnt < target && cycles < limit) begin
    drive_cycle(push_pct, 1'b1);
    cycles++;
  end
  if (pop_cnt < target) begin
    $display("%s timed out with %0d of %0d beats popped", name, pop_cnt, target);
    errors++;
  end
endtask

function automatic bit scoreboard_empty();
  bit empty;
  empty = 1'b1;
  for (int f = 0; f < num_flows; f++) begin
    if (exp_q[f].size() != 0 || src_q[f].size() != 0) begin
      empty = 1'b0;
    end
  end
  return empty;
endfunction

task automatic report_test(input string name, input int errors_before);
  tests_run++;
  if (errors == errors_before) begin
    $display("test %s passed", name);
  end else begin
    tests_failed++;
    $display("test %s failed with %0d errors", name, errors - errors_before);
  end
endtask

// ------------------------------------------------------------
// Tests
// ------------------------------------------------------------

task automatic check_reset_state();
  int errors_before;
  errors_before = errors;
  @(negedge clk);
  if (pop_valid !== 1'b0) begin
    $display("error: pop_valid after reset expected %h got %h", 1'b0, pop_valid);
    errors++;
  end
  if (push_ready !== {num_flows{1'b1}}) begin
    $display("error: push_ready after reset expected %h got %h", {num_flows{1'b1}}, push_ready);
    errors++;
  end
  @(posedge clk);
  report_test("reset_state", errors_before);
endtask

// Burst on flow 2 only, every pop must carry flow index 2
task automatic pass_single_flow();
  int errors_before;
  int target;
  errors_before = errors;
  pop_log.delete();
  target = pop_cnt + 8;
  for (int i = 0; i < 8; i++) begin
    src_q[2].push_back(data_width'(16'h2a00 + i));
  end
  run_until_popped(target, 100, 60, "single_flow");
  repeat (4) drive_cycle(0, 1'b1);
  if (pop_log.size() != 8) begin
    $display("single_flow popped %0d beats instead of 8", pop_log.size());
    errors++;
  end
  foreach (pop_log[i]) begin
    if (pop_log[i] != 2) begin
      $display("error: pop_flow on beat %0d expected %h got %h", i, 2, pop_log[i]);
      errors++;
    end
  end
  if (!scoreboard_empty()) begin
    $display("single_flow left pushed beats that never popped");
    errors++;
  end
  report_test("single_flow", errors_before);
endtask

// Equal bursts on all flows from reset, grant rotates 0, 1, 2, 3, 0 ...
task automatic rotate_round_robin();
  int errors_before;
  int target;
  errors_before = errors;
  // Reset puts flow 0 back at the highest priority
  reset_dut();
  pop_log.delete();
  target = pop_cnt + 16;
  for (int f = 0; f < num_flows; f++) begin
    for (int i = 0; i < 4; i++) begin
      src_q[f].push_back(data_width'(16'h3000 + f * 16 + i));
    end
  end
  run_until_popped(target, 100, 80, "round_robin");
  repeat (4) drive_cycle(0, 1'b1);
  if (pop_log.size() != 16) begin
    $display("round_robin popped %0d beats instead of 16", pop_log.size());
    errors++;
  end
  foreach (pop_log[i]) begin
    if (pop_log[i] != i % num_flows) begin
      $display("error: pop_flow on beat %0d expected %h got %h", i, i % num_flows, pop_log[i]);
      errors++;
    end
  end
  report_test("round_robin", errors_before);
endtask

// Consumer stalled, each buffer takes two beats then closes
task automatic hold_back_pressure();
  int                    errors_before;
  int                    target;
  int                    start_cnt [num_flows];
  logic [data_width-1:0] held;
  skid_state_e           st;
  errors_before = errors;
  target = pop_cnt + 8;
  for (int f = 0; f < num_flows; f++) begin
    start_cnt[f] = push_cnt[f];
    src_q[f].push_back(data_width'(16'h4000 + f * 16));
    src_q[f].push_back(data_width'(16'h4001 + f * 16));
  end
  repeat (8) drive_cycle(100, 1'b0);
  for (int f = 0; f < num_flows; f++) begin
    if (push_cnt[f] - start_cnt[f] != 2) begin
      $display("flow %0d accepted %0d beats while stalled instead of 2", f,
               push_cnt[f] - start_cnt[f]);
      errors++;
    end
  end
  @(negedge clk);
  // Round-robin test ended on flow 3, so the pointer is back at flow 0
  // Its first beat is the one on offer
  held = data_width'(16'h4000);
  st   = i_dut.g_flow[0].i_skid.state_q;
  if (push_ready !== '0) begin
    $display("error: push_ready while full expected %h got %h", 0, push_ready);
    errors++;
  end
  if (st != skid_two) begin
    $display("error: flow 0 skid state expected %h got %h (%s)", skid_two, st, st.name());
    errors++;
  end
  // Output must hold still while nothing is granted
  repeat (4) begin
    drive_cycle(0, 1'b0);
    @(negedge clk);
    if (pop_valid !== 1'b1 || pop_data !== held) begin
      $display("error: pop_valid, pop_data while stalled expected %h, %h got %h, %h",
               1'b1, held, pop_valid, pop_data);
      errors++;
    end
  end
  run_until_popped(target, 0, 40, "back_pressure");
  repeat (4) drive_cycle(0, 1'b1);
  if (pop_cnt != target || !scoreboard_empty()) begin
    $display("back_pressure lost or duplicated beats, %0d popped of %0d", pop_cnt, target);
    errors++;
  end
  report_test("back_pressure", errors_before);
endtask

// Random offers and random consumer stalls, then drain
task automatic stress_random_traffic();
  int errors_before;
  int pushed_before;
  int popped_before;
  int pushed;
  int cycles;
  errors_before = errors;
  pushed_before = 0;
  popped_before = pop_cnt;
  for (int f = 0; f < num_flows; f++) begin
    pushed_before += push_cnt[f];
    repeat (600) src_q[f].push_back(data_width'($urandom));
  end
  for (int c = 0; c < stress_cycles; c++) begin
    drive_cycle(60, $urandom_range(99) < 70);
  end
  // Offered beats still finish their handshake, unoffered ones are dropped
  for (int f = 0; f < num_flows; f++) begin
    src_q[f].delete();
  end
  cycles = 0;
  while (!(scoreboard_empty() && push_valid == '0) && cycles < 200) begin
    drive_cycle(0, 1'b1);
    cycles++;
  end
  repeat (4) drive_cycle(0, 1'b1);
  pushed = -pushed_before;
  for (int f = 0; f < num_flows; f++) begin
    pushed += push_cnt[f];
  end
  if (!scoreboard_empty() || pushed != pop_cnt - popped_before) begin
    $display("random_stress pushed %0d beats but popped %0d after draining", pushed,
             pop_cnt - popped_before);
    errors++;
  end
  report_test("random_stress", errors_before);
endtask

`endif // TB_FLOW_MERGE_TESTS_SVH

/* tb/tb_flow_merge.sv */
/*
 * Testbench top for the flow merger: clock, reset, DUT, transfer monitor
 * with per-flow scoreboard queues, watchdog and closing summary
 */

`timescale 1ns/100ps
`default_nettype none

module tb_flow_merge import flow_pkg::*; ();

  localparam int num_flows    = 4;
  localparam int data_width   = 16;
  localparam int clk_period   = 20;
  localparam int reset_cycles = 16;
  localparam int stress_cycles = 2000;

  // Cycle budget per test, resets included
  localparam int budget_total = 40 + 80 + 120 + 80 + stress_cycles + 300;

  logic                                 clk;
  logic                                 rst;
  logic [num_flows-1:0]                 push_valid;
  logic [num_flows-1:0]                 push_ready;
  logic [num_flows-1:0][data_width-1:0] push_data;
  logic                                 pop_valid;
  logic                                 pop_ready;
  logic [data_width-1:0]                pop_data;
  logic [$clog2(num_flows)-1:0]         pop_flow;

  // ----------------------------------------------------------
  // Scoreboard state
  // ----------------------------------------------------------

  // Beats not yet offered, per producer
  logic [data_width-1:0] src_q [num_flows][$];
  // Beats pushed into the DUT and not yet popped
  logic [data_width-1:0] exp_q [num_flows][$];
  // Source flow of every pop, in order
  int unsigned           pop_log [$];
  // Push handshake seen at the negedge, completes on the next rising edge
  logic [num_flows-1:0]  push_taken;
  int                    push_cnt [num_flows];
  int                    pop_cnt;
  int                    errors;
  int                    tests_run;
  int                    tests_failed;

  flow_merge_top #(
    .NumFlows (num_flows),
    .DataWidth(data_width)
  ) i_dut (
    .clk       (clk),
    .rst       (rst),
    .push_valid(push_valid),
    .push_ready(push_ready),
    .push_data (push_data),
    .pop_valid (pop_valid),
    .pop_ready (pop_ready),
    .pop_data  (pop_data),
    .pop_flow  (pop_flow)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  // Inputs change only on rising edges, so the negedge sees settled handshakes
  always @(negedge clk) begin : monitor
    logic [data_width-1:0] exp_word;
    for (int f = 0; f < num_flows; f++) begin
      push_taken[f] = !rst && push_valid[f] && push_ready[f];
      if (push_taken[f]) begin
        exp_q[f].push_back(push_data[f]);
        push_cnt[f]++;
      end
    end
    if (!rst && pop_valid && pop_ready) begin
      pop_cnt++;
      pop_log.push_back(pop_flow);
      if (exp_q[pop_flow].size() == 0) begin
        $display("pop on flow %0d with no beat outstanding, data %h", pop_flow, pop_data);
        errors++;
      end else begin
        exp_word = exp_q[pop_flow].pop_front();
        if (pop_data !== exp_word) begin
          $display("error: pop_data on flow %0d expected %h got %h", pop_flow, exp_word,
                   pop_data);
          errors++;
        end
      end
    end
  end

  // Bounded run time
  initial begin : watchdog
    #(budget_total * clk_period + 2000);
    $display("watchdog expired after %0d cycles, run did not complete", budget_total);
    $display("Finished with errors");
    $finish;
  end

  `include "tb_flow_merge_tests.svh"

  initial begin : main
    rst        = 1'b1;
    push_valid = '0;
    push_data  = '0;
    pop_ready  = 1'b0;
    push_taken = '0;
    void'($urandom(32'h5ab7ef7b));
    reset_dut();
    check_reset_state();
    pass_single_flow();
    rotate_round_robin();
    hold_back_pressure();
    stress_random_traffic();
    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule : tb_flow_merge

`default_nettype wire

/* list.f */
+incdir+tb
source/flow_pkg.sv
source/flow_skid.sv
source/flow_arb_rr.sv
source/flow_mux_rr.sv
source/flow_merge_top.sv
tb/tb_flow_merge.sv

/* Bender.yml */
package:
  name: flow_merge

sources:
  - files:
      - source/flow_pkg.sv
      - source/flow_skid.sv
      - source/flow_arb_rr.sv
      - source/flow_mux_rr.sv
      - source/flow_merge_top.sv
  - target: test
    include_dirs:
      - tb
    files:
      - tb/tb_flow_merge.sv
